// ==== rtl/ex_pkg.sv ====
package ex_pkg;

    localparam int XLEN       = 32;
    localparam int SHAMT_W    = 5;
    localparam int REG_ADDR_W = 5;
    localparam int INSN_BYTES = 4;  // pc step
    localparam int UOP_W      = 6;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // x1 and x5 act as link registers for the return-address stack
    localparam reg_addr_t LINK_RA = reg_addr_t'(1);
    localparam reg_addr_t LINK_T0 = reg_addr_t'(5);

    typedef enum logic [UOP_W-1:0] {
        UOP_NOP,
        UOP_ADD, UOP_SUB, UOP_ADDI,
        UOP_LUI, UOP_AUIPC,
        UOP_SLT, UOP_SLTU, UOP_SLTI, UOP_SLTIU,
        UOP_AND, UOP_OR, UOP_XOR,
        UOP_ANDI, UOP_ORI, UOP_XORI,
        UOP_SLL, UOP_SRL, UOP_SRA,
        UOP_SLLI, UOP_SRLI, UOP_SRAI,
        UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
        UOP_JAL, UOP_JALR,
        UOP_LB, UOP_LBU, UOP_LH, UOP_LHU, UOP_LW,
        UOP_SB, UOP_SH, UOP_SW
    } uop_e;

    // which unit's value goes to rd
    typedef enum logic [2:0] {
        CLS_ARITH,
        CLS_LOGIC,
        CLS_SHIFT,
        CLS_BRANCH,
        CLS_MEM,
        CLS_NONE
    } res_class_e;

    typedef struct packed {
        word_t      pc;
        uop_e       uop;
        res_class_e res_class;
        reg_addr_t  rs1_a;       // needed for ret detection
        word_t      rs1_d;
        word_t      rs2_d;
        word_t      imm;
        logic       rd_we;
        reg_addr_t  rd_a;
        logic       pred_taken;  // fetch prediction
        word_t      pred_pc;
    } ex_req_t;

    typedef struct packed {
        word_t      pc;
        uop_e       uop;         // lsu tells load from store by this
        logic       rd_we;
        reg_addr_t  rd_a;
        word_t      rd_wd;
        word_t      mem_a;
        word_t      mem_wd;
    } ex_res_t;

    typedef struct packed {
        logic       request;     // branch or jump
        logic       taken;
        logic       is_call;
        logic       is_ret;
        logic       is_jmp;
        word_t      target;
        logic       redirect;    // mispredicted
        word_t      redirect_pc;
    } br_res_t;

    function automatic logic is_link_reg(reg_addr_t a);
        return (a == LINK_RA) || (a == LINK_T0);
    endfunction

endpackage

// ==== rtl/ex_issue_reg.sv ====
module ex_issue_reg
    import ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  logic    req_valid_i,
    input  ex_req_t req_i,
    output logic    valid_o,
    output ex_req_t req_o
);

    logic    valid_q;
    ex_req_t req_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid_i;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            req_q <= req_i;
        end else begin
            // idle slot carries a neutral op so the units stay quiet
            req_q.uop        <= UOP_NOP;
            req_q.res_class  <= CLS_NONE;
            req_q.rd_we      <= 1'b0;
            req_q.pred_taken <= 1'b0;
        end
    end

    assign valid_o = valid_q;
    assign req_o   = req_q;

endmodule

// ==== rtl/ex_alu.sv ====
module ex_alu
    import ex_pkg::*;
(
    input  ex_req_t req_i,
    output word_t   wd_o,
    output word_t   mem_a_o,
    output word_t   mem_wd_o
);

    logic               use_imm;
    word_t              op_b;
    logic [SHAMT_W-1:0] shamt;
    word_t              sum;
    word_t              diff;
    word_t              addr;
    logic               lt_s;
    logic               lt_u;
    word_t              arith_r;
    word_t              logic_r;
    word_t              shift_r;

    // immediate forms take imm as the second operand
    always_comb begin
        case (req_i.uop)
            UOP_ADDI, UOP_SLTI, UOP_SLTIU, UOP_ANDI, UOP_ORI, UOP_XORI,
            UOP_SLLI, UOP_SRLI, UOP_SRAI: use_imm = 1'b1;
            default:                      use_imm = 1'b0;
        endcase
    end

    assign op_b  = use_imm ? req_i.imm : req_i.rs2_d;
    assign shamt = op_b[SHAMT_W-1:0];  // upper bits ignored
    assign sum   = req_i.rs1_d + op_b;
    assign diff  = req_i.rs1_d - op_b;
    assign addr  = req_i.rs1_d + req_i.imm;
    assign lt_s  = $signed(req_i.rs1_d) < $signed(op_b);
    assign lt_u  = req_i.rs1_d < op_b;

    always_comb begin
        case (req_i.uop)
            UOP_ADD, UOP_ADDI: arith_r = sum;
            UOP_SUB:           arith_r = diff;
            default:           arith_r = '0;
        endcase
    end

    always_comb begin
        case (req_i.uop)
            UOP_LUI:             logic_r = req_i.imm;
            UOP_AUIPC:           logic_r = req_i.pc + req_i.imm;
            UOP_SLT, UOP_SLTI:   logic_r = word_t'(lt_s);
            UOP_SLTU, UOP_SLTIU: logic_r = word_t'(lt_u);
            UOP_AND, UOP_ANDI:   logic_r = req_i.rs1_d & op_b;
            UOP_OR, UOP_ORI:     logic_r = req_i.rs1_d | op_b;
            UOP_XOR, UOP_XORI:   logic_r = req_i.rs1_d ^ op_b;
            default:             logic_r = '0;
        endcase
    end

    always_comb begin
        case (req_i.uop)
            UOP_SLL, UOP_SLLI: shift_r = req_i.rs1_d << shamt;
            UOP_SRL, UOP_SRLI: shift_r = req_i.rs1_d >> shamt;
            // sign fill
            UOP_SRA, UOP_SRAI: shift_r = word_t'($signed(req_i.rs1_d) >>> shamt);
            default:           shift_r = '0;
        endcase
    end

    always_comb begin
        case (req_i.res_class)
            CLS_ARITH: wd_o = arith_r;
            CLS_LOGIC: wd_o = logic_r;
            CLS_SHIFT: wd_o = shift_r;
            default:   wd_o = '0;  // branch/mem handled downstream
        endcase
    end

    // load/store address and store data
    always_comb begin
        mem_a_o  = '0;
        mem_wd_o = '0;
        case (req_i.uop)
            UOP_LB, UOP_LBU, UOP_LH, UOP_LHU, UOP_LW: begin
                mem_a_o = addr;
            end
            UOP_SB, UOP_SH, UOP_SW: begin
                mem_a_o  = addr;
                mem_wd_o = req_i.rs2_d;  // lsu picks the byte lanes
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== rtl/ex_branch_unit.sv ====
module ex_branch_unit
    import ex_pkg::*;
(
    input  ex_req_t req_i,
    output word_t   link_wd_o,
    output br_res_t br_o
);

    word_t   pc_plus4;
    word_t   pc_imm;
    word_t   rs1_imm;
    logic    eq;
    logic    lt_s;
    logic    lt_u;
    logic    rd_link;
    logic    rs1_link;
    br_res_t br;

    assign pc_plus4 = req_i.pc + word_t'(INSN_BYTES);
    assign pc_imm   = req_i.pc + req_i.imm;
    assign rs1_imm  = req_i.rs1_d + req_i.imm;
    assign eq       = req_i.rs1_d == req_i.rs2_d;
    assign lt_s     = $signed(req_i.rs1_d) < $signed(req_i.rs2_d);
    assign lt_u     = req_i.rs1_d < req_i.rs2_d;

    assign rd_link  = is_link_reg(req_i.rd_a);
    assign rs1_link = is_link_reg(req_i.rs1_a);

    always_comb begin
        br        = '0;
        link_wd_o = '0;
        case (req_i.uop)
            UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU: begin
                br.request = 1'b1;
                br.target  = pc_imm;
                case (req_i.uop)
                    UOP_BEQ:  br.taken = eq;
                    UOP_BNE:  br.taken = !eq;
                    UOP_BLT:  br.taken = lt_s;
                    UOP_BGE:  br.taken = !lt_s;
                    UOP_BLTU: br.taken = lt_u;
                    default:  br.taken = !lt_u;  // bgeu
                endcase
            end
            UOP_JAL: begin
                br.request = 1'b1;
                br.taken   = 1'b1;
                br.target  = pc_imm;
                link_wd_o  = pc_plus4;
                if (rd_link) begin
                    br.is_call = 1'b1;
                end else begin
                    br.is_jmp = 1'b1;
                end
            end
            UOP_JALR: begin
                br.request = 1'b1;
                br.taken   = 1'b1;
                br.target  = rs1_imm;
                link_wd_o  = pc_plus4;
                // ras push/pop rules from the link-register hints
                if (rd_link) begin
                    br.is_call = 1'b1;
                    if (rs1_link && (req_i.rs1_a != req_i.rd_a)) begin
                        br.is_ret = 1'b1;  // push and pop
                    end
                end else if (rs1_link) begin
                    br.is_ret = 1'b1;
                end else begin
                    br.is_jmp = 1'b1;
                end
            end
            default: begin
            end
        endcase

        // compare outcome with the fetch prediction
        if (br.request) begin
            if (br.taken) begin
                if (!req_i.pred_taken || (req_i.pred_pc != br.target)) begin
                    br.redirect    = 1'b1;
                    br.redirect_pc = br.target;
                end
            end else if (req_i.pred_taken) begin
                br.redirect    = 1'b1;
                br.redirect_pc = pc_plus4;  // fall through
            end
        end
    end

    assign br_o = br;

endmodule

// ==== rtl/ex_commit_reg.sv ====
module ex_commit_reg
    import ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  logic    valid_i,
    input  ex_req_t req_i,
    input  word_t   alu_wd_i,
    input  word_t   link_wd_i,
    input  word_t   mem_a_i,
    input  word_t   mem_wd_i,
    input  br_res_t br_i,
    output logic    valid_o,
    output ex_res_t res_o,
    output br_res_t br_o,
    output logic    redirect_o,
    output word_t   redirect_pc_o
);

    word_t   wd;
    ex_res_t res_d;
    br_res_t br_d;
    logic    valid_q;
    ex_res_t res_q;
    br_res_t br_q;

    // writeback value by result class
    always_comb begin
        case (req_i.res_class)
            CLS_ARITH, CLS_LOGIC, CLS_SHIFT: wd = alu_wd_i;
            CLS_BRANCH:                      wd = link_wd_i;
            default:                         wd = '0;
        endcase
    end

    always_comb begin
        res_d.pc     = req_i.pc;
        res_d.uop    = req_i.uop;
        res_d.rd_we  = valid_i && req_i.rd_we;
        res_d.rd_a   = req_i.rd_a;
        res_d.rd_wd  = wd;
        res_d.mem_a  = mem_a_i;
        res_d.mem_wd = mem_wd_i;

        br_d          = br_i;
        br_d.request  = valid_i && br_i.request;  // empty slot never branches
        br_d.taken    = valid_i && br_i.taken;
        br_d.is_call  = valid_i && br_i.is_call;
        br_d.is_ret   = valid_i && br_i.is_ret;
        br_d.is_jmp   = valid_i && br_i.is_jmp;
        br_d.redirect = valid_i && br_i.redirect;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q     <= 1'b0;
            res_q.rd_we <= 1'b0;  // only the flags get cleared
            br_q.request  <= 1'b0;
            br_q.taken    <= 1'b0;
            br_q.is_call  <= 1'b0;
            br_q.is_ret   <= 1'b0;
            br_q.is_jmp   <= 1'b0;
            br_q.redirect <= 1'b0;
        end else begin
            valid_q <= valid_i;
            res_q   <= res_d;
            br_q    <= br_d;
        end
    end

    assign valid_o       = valid_q;
    assign res_o         = res_q;
    assign br_o          = br_q;
    assign redirect_o    = valid_q && br_q.redirect;  // one cycle pulse
    assign redirect_pc_o = br_q.redirect_pc;

endmodule

// ==== rtl/ex_stage.sv ====
module ex_stage
    import ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  logic    req_valid_i,
    input  ex_req_t req_i,
    output logic    res_valid_o,
    output ex_res_t res_o,
    output br_res_t br_o,
    output logic    redirect_o,
    output word_t   redirect_pc_o
);

    logic    issue_valid;
    ex_req_t issue_req;
    word_t   alu_wd;
    word_t   mem_a;
    word_t   mem_wd;
    word_t   link_wd;
    br_res_t br;

    ex_issue_reg u_issue (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .valid_o     (issue_valid),
        .req_o       (issue_req)
    );

    ex_alu u_alu (
        .req_i    (issue_req),
        .wd_o     (alu_wd),
        .mem_a_o  (mem_a),
        .mem_wd_o (mem_wd)
    );

    ex_branch_unit u_branch (
        .req_i     (issue_req),
        .link_wd_o (link_wd),
        .br_o      (br)
    );

    // second register stage, two cycles total
    ex_commit_reg u_commit (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (issue_valid),
        .req_i         (issue_req),
        .alu_wd_i      (alu_wd),
        .link_wd_i     (link_wd),
        .mem_a_i       (mem_a),
        .mem_wd_i      (mem_wd),
        .br_i          (br),
        .valid_o       (res_valid_o),
        .res_o         (res_o),
        .br_o          (br_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

// ==== tests/ex_ref_model.svh ====
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// signed compare from the sign bits, then magnitude
function automatic logic signed_less(word_t a, word_t b);
    return (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
endfunction

function automatic word_t shift_right_arith(word_t a, logic [SHAMT_W-1:0] sh);
    word_t fill;
    fill = ~({XLEN{1'b1}} >> sh);  // vacated upper bits
    return (a >> sh) | (a[XLEN-1] ? fill : '0);
endfunction

function automatic word_t writeback_value(ex_req_t r);
    case (r.uop)
        UOP_ADD:   return r.rs1_d + r.rs2_d;
        UOP_SUB:   return r.rs1_d - r.rs2_d;
        UOP_ADDI:  return r.rs1_d + r.imm;
        UOP_LUI:   return r.imm;
        UOP_AUIPC: return r.pc + r.imm;
        UOP_SLT:   return word_t'(signed_less(r.rs1_d, r.rs2_d));
        UOP_SLTI:  return word_t'(signed_less(r.rs1_d, r.imm));
        UOP_SLTU:  return word_t'(r.rs1_d < r.rs2_d);
        UOP_SLTIU: return word_t'(r.rs1_d < r.imm);
        UOP_AND:   return r.rs1_d & r.rs2_d;
        UOP_ANDI:  return r.rs1_d & r.imm;
        UOP_OR:    return r.rs1_d | r.rs2_d;
        UOP_ORI:   return r.rs1_d | r.imm;
        UOP_XOR:   return r.rs1_d ^ r.rs2_d;
        UOP_XORI:  return r.rs1_d ^ r.imm;
        UOP_SLL:   return r.rs1_d << r.rs2_d[SHAMT_W-1:0];
        UOP_SLLI:  return r.rs1_d << r.imm[SHAMT_W-1:0];
        UOP_SRL:   return r.rs1_d >> r.rs2_d[SHAMT_W-1:0];
        UOP_SRLI:  return r.rs1_d >> r.imm[SHAMT_W-1:0];
        UOP_SRA:   return shift_right_arith(r.rs1_d, r.rs2_d[SHAMT_W-1:0]);
        UOP_SRAI:  return shift_right_arith(r.rs1_d, r.imm[SHAMT_W-1:0]);
        UOP_JAL, UOP_JALR: return r.pc + 32'd4;  // link value
        default:   return '0;  // loads, stores, conditional branches
    endcase
endfunction

function automatic ex_res_t expected_result(ex_req_t r);
    ex_res_t e;
    logic    is_ld;
    logic    is_st;
    is_ld    = r.uop inside {UOP_LB, UOP_LBU, UOP_LH, UOP_LHU, UOP_LW};
    is_st    = r.uop inside {UOP_SB, UOP_SH, UOP_SW};
    e.pc     = r.pc;
    e.uop    = r.uop;
    e.rd_we  = r.rd_we;
    e.rd_a   = r.rd_a;
    e.rd_wd  = writeback_value(r);
    e.mem_a  = (is_ld || is_st) ? r.rs1_d + r.imm : '0;
    e.mem_wd = is_st ? r.rs2_d : '0;
    return e;
endfunction

function automatic br_res_t resolve_branch(ex_req_t r);
    br_res_t b;
    logic    rd_lnk;
    logic    rs1_lnk;
    b       = '0;
    rd_lnk  = r.rd_a inside {LINK_RA, LINK_T0};
    rs1_lnk = r.rs1_a inside {LINK_RA, LINK_T0};
    b.request = 1'b1;
    case (r.uop)
        UOP_BEQ:  b.taken = r.rs1_d == r.rs2_d;
        UOP_BNE:  b.taken = r.rs1_d != r.rs2_d;
        UOP_BLT:  b.taken = signed_less(r.rs1_d, r.rs2_d);
        UOP_BGE:  b.taken = !signed_less(r.rs1_d, r.rs2_d);
        UOP_BLTU: b.taken = r.rs1_d < r.rs2_d;
        UOP_BGEU: b.taken = r.rs1_d >= r.rs2_d;
        UOP_JAL, UOP_JALR: b.taken = 1'b1;
        default:  b.request = 1'b0;
    endcase
    if (!b.request) begin
        return b;
    end
    b.target = (r.uop == UOP_JALR) ? r.rs1_d + r.imm : r.pc + r.imm;
    if (r.uop == UOP_JAL) begin
        b.is_call = rd_lnk;
        b.is_jmp  = !rd_lnk;
    end else if (r.uop == UOP_JALR) begin
        b.is_call = rd_lnk;
        b.is_ret  = rs1_lnk && (!rd_lnk || r.rs1_a != r.rd_a);
        b.is_jmp  = !rd_lnk && !rs1_lnk;
    end
    if (b.taken && (!r.pred_taken || r.pred_pc != b.target)) begin
        b.redirect    = 1'b1;
        b.redirect_pc = b.target;
    end else if (!b.taken && r.pred_taken) begin
        b.redirect    = 1'b1;
        b.redirect_pc = r.pc + 32'd4;  // fall through
    end
    return b;
endfunction

`endif

// ==== tests/tb_ex_stage.sv ====
module tb_ex_stage
    import ex_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        ex_res_t     res;
        br_res_t     br;
        logic [31:0] due;  // cycle count when the result is sampled
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_i;
    logic        req_valid_i;
    ex_req_t     req_i;
    logic        res_valid_o;
    ex_res_t     res_o;
    br_res_t     br_o;
    logic        redirect_o;
    word_t       redirect_pc_o;
    logic [31:0] cyc = '0;
    exp_t        exp_q[$];
    exp_t        head = '0;
    logic        head_ok = 1'b0;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          test_cnt = 0;
    reg_addr_t   jmp_rd[7]  = '{1, 7, 1, 5, 1, 0, 3};  // jal link, jal plain, then jalr cases
    reg_addr_t   jmp_rs1[7] = '{2, 2, 5, 5, 9, 1, 4};

    `include "ex_ref_model.svh"

    ex_stage dut0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .res_valid_o   (res_valid_o),
        .res_o         (res_o),
        .br_o          (br_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 32'd1;

    // head settles mid-cycle, stable for the next edge
    always @(negedge clk) begin
        head_ok = exp_q.size() > 0;
        if (head_ok) begin
            head = exp_q[0];
        end
    end

    always @(posedge clk) begin
        if (!rst_i && res_valid_o && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            chk_cnt++;
        end
    end

    a_due: assert property (@(posedge clk) disable iff (rst_i)
        res_valid_o == (head_ok && head.due == cyc))
        else begin
            err_cnt++;
            $display("Mismatch at %0t: res_valid_o %b, expected %b", $time,
                $sampled(res_valid_o), $sampled(head_ok && head.due == cyc));
        end

    a_res: assert property (@(posedge clk) disable iff (rst_i)
        res_valid_o |-> res_o == head.res)
        else begin
            err_cnt++;
            $display("Mismatch at %0t: result for pc %h uop %s rd_wd %h exp %h mem_a %h exp %h",
                $time, $sampled(res_o.pc), head.res.uop.name(), $sampled(res_o.rd_wd),
                head.res.rd_wd, $sampled(res_o.mem_a), head.res.mem_a);
        end

    a_br: assert property (@(posedge clk) disable iff (rst_i)
        res_valid_o |-> br_o == head.br)
        else begin
            err_cnt++;
            $display("Mismatch at %0t: branch record for pc %h got %h exp %h", $time,
                $sampled(res_o.pc), $sampled(br_o), head.br);
        end

    a_redirect: assert property (@(posedge clk) disable iff (rst_i)
        redirect_o == (res_valid_o && head.br.redirect)
        && (!redirect_o || redirect_pc_o == head.br.redirect_pc))
        else begin
            err_cnt++;
            $display("Mismatch at %0t: redirect_o %b to %h, expected %b to %h", $time,
                $sampled(redirect_o), $sampled(redirect_pc_o),
                $sampled(res_valid_o) && head.br.redirect, head.br.redirect_pc);
        end

    a_idle: assert property (@(posedge clk) disable iff (rst_i)
        !res_valid_o |-> !redirect_o && !res_o.rd_we && !br_o.request && !br_o.taken
        && !br_o.is_call && !br_o.is_ret && !br_o.is_jmp && !br_o.redirect)
        else begin
            err_cnt++;
            $display("Mismatch at %0t: flags raised on an empty slot", $time);
        end

    function automatic res_class_e class_of(uop_e u);
        if (u >= UOP_LB) return CLS_MEM;
        if (u >= UOP_BEQ) return CLS_BRANCH;
        if (u >= UOP_SLL) return CLS_SHIFT;
        if (u inside {UOP_ADD, UOP_SUB, UOP_ADDI}) return CLS_ARITH;
        return CLS_LOGIC;  // lui, auipc, compares, logic ops
    endfunction

    function automatic ex_req_t rand_req(uop_e u);
        ex_req_t r;
        r.pc         = $urandom() & 32'hffff_fffc;
        r.uop        = u;
        r.res_class  = class_of(u);
        r.rs1_a      = reg_addr_t'($urandom());
        r.rs1_d      = $urandom();
        r.rs2_d      = ($urandom_range(0, 3) == 0) ? r.rs1_d : $urandom();  // equal operands
        r.imm        = $urandom();
        r.rd_a       = reg_addr_t'($urandom());
        r.rd_we      = (r.rd_a != 0) && !(u inside {[UOP_BEQ:UOP_BGEU], [UOP_SB:UOP_SW]});
        r.pred_taken = $urandom_range(0, 1);
        r.pred_pc    = $urandom() & 32'hffff_fffc;
        return r;
    endfunction

    task automatic send(ex_req_t r);
        exp_t e;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= r;
        e.res = expected_result(r);
        e.br  = resolve_branch(r);
        e.due = cyc + 32'd3;  // taken at the next edge, out two edges later
        exp_q.push_back(e);
    endtask

    task automatic finish_test(string name, int err0);
        int n;
        n = 0;
        @(posedge clk);
        req_valid_i <= 1'b0;
        while (exp_q.size() > 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("test %s timed out, %0d results never came out", name, exp_q.size());
            $display("TB FAILED");
            $finish;
        end else begin
            test_cnt++;
            $display("test %-10s %s, %0d errors", name, (err_cnt == err0) ? "ok" : "failed",
                err_cnt - err0);
        end
    endtask

    initial begin
        int      err0;
        ex_req_t r;
        br_res_t b;
        void'($urandom(25));
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;

        err0 = err_cnt;
        repeat (10) @(posedge clk);  // nothing issued, outputs stay quiet
        finish_test("reset_idle", err0);

        err0 = err_cnt;
        for (int i = 0; i < 60; i++) begin
            send(rand_req(uop_e'($urandom_range(UOP_ADD, UOP_SRAI))));
        end
        finish_test("alu", err0);

        err0 = err_cnt;
        for (int i = 0; i < 36; i++) begin
            r = rand_req(uop_e'($urandom_range(UOP_BEQ, UOP_BGEU)));
            b = resolve_branch(r);
            case (i % 3)
                0: begin  // correct prediction
                    r.pred_taken = b.taken;
                    r.pred_pc    = b.taken ? b.target : r.pc + 32'd4;
                end
                1: begin  // wrong direction
                    r.pred_taken = !b.taken;
                    r.pred_pc    = b.target;
                end
                default: begin  // wrong target
                    r.pred_taken = 1'b1;
                    r.pred_pc    = b.target ^ 32'h10;
                end
            endcase
            send(r);
        end
        finish_test("branch", err0);

        err0 = err_cnt;
        for (int i = 0; i < 14; i++) begin
            r       = rand_req((i % 7 < 2) ? UOP_JAL : UOP_JALR);
            r.rd_a  = jmp_rd[i % 7];
            r.rs1_a = jmp_rs1[i % 7];
            r.rd_we = r.rd_a != 0;
            send(r);
        end
        finish_test("jump", err0);

        err0 = err_cnt;
        for (int i = 0; i < 30; i++) begin
            send(rand_req(uop_e'($urandom_range(UOP_LB, UOP_SW))));
        end
        finish_test("mem", err0);

        err0 = err_cnt;
        for (int i = 0; i < 50; i++) begin
            send(rand_req(uop_e'($urandom_range(UOP_ADD, UOP_SW))));
        end
        finish_test("stream", err0);

        $display("%0d tests, %0d results checked, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+tests
rtl/ex_pkg.sv
rtl/ex_issue_reg.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/ex_commit_reg.sv
rtl/ex_stage.sv
tests/tb_ex_stage.sv
